// ==== src/mem_bus_pkg.sv ====
package mem_bus_pkg;

  // requester side
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // shared bus, two requester words wide
  localparam int BUS_W  = 64;
  localparam int STRB_W = BUS_W / 8;

  // access size codes, log2 of bytes
  localparam int SIZE_W = 2;
  localparam logic [SIZE_W-1:0] SIZE_BYTE = 2'd0;
  localparam logic [SIZE_W-1:0] SIZE_HALF = 2'd1;
  localparam logic [SIZE_W-1:0] SIZE_WORD = 2'd2;

  // core-local timer, mtime halves
  localparam logic [ADDR_W-1:0] MTIME_LO_ADDR = 32'h0200_bff8;
  localparam logic [ADDR_W-1:0] MTIME_HI_ADDR = 32'h0200_bffc;

  // on-chip sram, indexed by addr[10:3]
  localparam int MEM_WORDS = 256;
  localparam int MEM_IDX_W = 8;

endpackage

// ==== src/bus_arbiter.sv ====
module bus_arbiter (
  input  logic                              clk,
  input  logic                              rst,
  // fetch port
  input  logic                              ifu_req_valid_i,
  output logic                              ifu_req_ready_o,
  input  logic [mem_bus_pkg::ADDR_W-1:0]    ifu_addr_i,
  output logic                              ifu_rsp_valid_o,
  output logic [mem_bus_pkg::DATA_W-1:0]    ifu_rsp_data_o,
  // load/store port
  input  logic                              lsu_req_valid_i,
  output logic                              lsu_req_ready_o,
  input  logic                              lsu_we_i,
  input  logic [mem_bus_pkg::ADDR_W-1:0]    lsu_addr_i,
  input  logic [mem_bus_pkg::SIZE_W-1:0]    lsu_size_i,
  input  logic [mem_bus_pkg::DATA_W-1:0]    lsu_wdata_i,
  output logic                              lsu_rsp_valid_o,
  output logic [mem_bus_pkg::DATA_W-1:0]    lsu_rsp_data_o,
  // read bus
  output logic                              ar_valid_o,
  input  logic                              ar_ready_i,
  output logic [mem_bus_pkg::ADDR_W-1:0]    ar_addr_o,
  input  logic                              r_valid_i,
  input  logic [mem_bus_pkg::BUS_W-1:0]     r_data_i,
  // write bus
  output logic                              aw_valid_o,
  input  logic                              aw_ready_i,
  output logic [mem_bus_pkg::ADDR_W-1:0]    aw_addr_o,
  output logic [mem_bus_pkg::BUS_W-1:0]     w_data_o,
  output logic [mem_bus_pkg::STRB_W-1:0]    w_strb_o,
  input  logic                              b_valid_i,
  // timer port
  output logic                              tmr_rd_valid_o,
  output logic                              tmr_rd_hi_o,
  input  logic                              tmr_rsp_valid_i,
  input  logic [mem_bus_pkg::DATA_W-1:0]    tmr_rsp_data_i
);

  typedef enum logic [1:0] {IDLE, BUS_READ, BUS_WRITE, TIMER_READ} state_t;

  state_t state_q;
  logic   up_q;      // low for the first cycle out of reset
  logic   sent_q;    // downstream request already taken
  logic   gnt_lsu_q;
  logic   we_q;

  logic [mem_bus_pkg::ADDR_W-1:0] addr_q;
  logic [mem_bus_pkg::SIZE_W-1:0] size_q;
  logic [mem_bus_pkg::DATA_W-1:0] wdata_q;

  logic lsu_hs;
  logic ifu_hs;
  logic lsu_timer;

  logic [mem_bus_pkg::DATA_W-1:0] ld_half;
  logic [mem_bus_pkg::DATA_W-1:0] ld_shift;
  logic [mem_bus_pkg::DATA_W-1:0] ld_data;
  logic [mem_bus_pkg::DATA_W-1:0] st_lane;
  logic [mem_bus_pkg::STRB_W-1:0] strb_base;

  // load/store has priority over fetch
  assign lsu_req_ready_o = up_q & (state_q == IDLE);
  assign ifu_req_ready_o = up_q & (state_q == IDLE) & ~lsu_req_valid_i;

  assign lsu_hs = lsu_req_valid_i & lsu_req_ready_o;
  assign ifu_hs = ifu_req_valid_i & ifu_req_ready_o;

  assign lsu_timer = (lsu_addr_i == mem_bus_pkg::MTIME_LO_ADDR) |
                     (lsu_addr_i == mem_bus_pkg::MTIME_HI_ADDR);

  assign ar_valid_o     = (state_q == BUS_READ) & ~sent_q;
  assign ar_addr_o      = addr_q;
  assign aw_valid_o     = (state_q == BUS_WRITE) & ~sent_q;
  assign aw_addr_o      = addr_q;
  assign tmr_rd_valid_o = (state_q == TIMER_READ) & ~sent_q;
  assign tmr_rd_hi_o    = (addr_q == mem_bus_pkg::MTIME_HI_ADDR);

  // lane placement
  always_comb
  begin
    case (size_q)
      mem_bus_pkg::SIZE_BYTE: strb_base = 8'h01;
      mem_bus_pkg::SIZE_HALF: strb_base = 8'h03;
      default:                strb_base = 8'h0f;
    endcase

    st_lane  = wdata_q << {addr_q[1:0], 3'b000};
    ld_half  = addr_q[2] ? r_data_i[63:32] : r_data_i[31:0];
    ld_shift = ld_half >> {addr_q[1:0], 3'b000};

    case (size_q) // zero extend
      mem_bus_pkg::SIZE_BYTE: ld_data = {24'b0, ld_shift[7:0]};
      mem_bus_pkg::SIZE_HALF: ld_data = {16'b0, ld_shift[15:0]};
      default:                ld_data = ld_shift;
    endcase
  end

  assign w_data_o = {st_lane, st_lane};
  assign w_strb_o = strb_base << addr_q[2:0];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q         <= IDLE;
      up_q            <= 1'b0;
      sent_q          <= 1'b0;
      gnt_lsu_q       <= 1'b0;
      we_q            <= 1'b0;
      ifu_rsp_valid_o <= 1'b0;
      lsu_rsp_valid_o <= 1'b0;
    end
    else
    begin
      up_q            <= 1'b1;
      ifu_rsp_valid_o <= 1'b0;
      lsu_rsp_valid_o <= 1'b0;
      case (state_q)
        IDLE:
        begin
          sent_q <= 1'b0;
          if (lsu_hs)
          begin
            gnt_lsu_q <= 1'b1;
            we_q      <= lsu_we_i;
            if (lsu_timer)
              state_q <= TIMER_READ; // timer stores also land here
            else if (lsu_we_i)
              state_q <= BUS_WRITE;
            else
              state_q <= BUS_READ;
          end
          else if (ifu_hs)
          begin
            gnt_lsu_q <= 1'b0;
            we_q      <= 1'b0;
            state_q   <= BUS_READ;
          end
        end
        BUS_READ:
        begin
          if (ar_valid_o & ar_ready_i)
            sent_q <= 1'b1;
          if (r_valid_i)
          begin
            state_q         <= IDLE;
            lsu_rsp_valid_o <= gnt_lsu_q;
            ifu_rsp_valid_o <= ~gnt_lsu_q;
          end
        end
        BUS_WRITE:
        begin
          if (aw_valid_o & aw_ready_i)
            sent_q <= 1'b1;
          if (b_valid_i)
          begin
            state_q         <= IDLE;
            lsu_rsp_valid_o <= 1'b1;
          end
        end
        TIMER_READ:
        begin
          if (tmr_rd_valid_o)
            sent_q <= 1'b1; // timer never stalls
          if (tmr_rsp_valid_i)
          begin
            state_q         <= IDLE;
            lsu_rsp_valid_o <= 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // request and response payload
  always_ff @(posedge clk)
  begin
    if (lsu_hs)
    begin
      addr_q  <= lsu_addr_i;
      size_q  <= lsu_size_i;
      wdata_q <= lsu_wdata_i;
    end
    else if (ifu_hs)
    begin
      addr_q <= ifu_addr_i;
      size_q <= mem_bus_pkg::SIZE_WORD; // fetch is always a word
    end

    if ((state_q == BUS_READ) & r_valid_i)
    begin
      if (gnt_lsu_q)
        lsu_rsp_data_o <= ld_data;
      else
        ifu_rsp_data_o <= ld_data;
    end
    if ((state_q == BUS_WRITE) & b_valid_i)
      lsu_rsp_data_o <= '0;
    if ((state_q == TIMER_READ) & tmr_rsp_valid_i)
      lsu_rsp_data_o <= we_q ? '0 : tmr_rsp_data_i;
  end

endmodule

// ==== src/clint_timer.sv ====
module clint_timer (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           rd_valid_i,
  input  logic                           rd_hi_i,
  output logic                           rsp_valid_o,
  output logic [mem_bus_pkg::DATA_W-1:0] rsp_data_o
);

  // 64-bit mtime as two requester words
  logic [2*mem_bus_pkg::DATA_W-1:0] mtime_q;
  logic [mem_bus_pkg::DATA_W-1:0]   mtime_lo;
  logic [mem_bus_pkg::DATA_W-1:0]   mtime_hi;

  assign mtime_lo = mtime_q[mem_bus_pkg::DATA_W-1:0];
  assign mtime_hi = mtime_q[2*mem_bus_pkg::DATA_W-1:mem_bus_pkg::DATA_W];

  // free running, zero in the first cycle after reset
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime_q     <= '0;
      rsp_valid_o <= 1'b0;
    end
    else
    begin
      mtime_q     <= mtime_q + 1'b1;
      rsp_valid_o <= rd_valid_i; // one cycle later
    end
  end

  // sample the half at the request edge
  always_ff @(posedge clk)
  begin
    if (rd_valid_i)
    begin
      if (rd_hi_i)
        rsp_data_o <= mtime_hi;
      else
        rsp_data_o <= mtime_lo;
    end
  end

endmodule

// ==== src/sram_slave.sv ====
module sram_slave (
  input  logic                           clk,
  input  logic                           rst,
  // read channel
  input  logic                           ar_valid_i,
  output logic                           ar_ready_o,
  input  logic [mem_bus_pkg::ADDR_W-1:0] ar_addr_i,
  output logic                           r_valid_o,
  output logic [mem_bus_pkg::BUS_W-1:0]  r_data_o,
  // write channel, address and data together
  input  logic                           aw_valid_i,
  output logic                           aw_ready_o,
  input  logic [mem_bus_pkg::ADDR_W-1:0] aw_addr_i,
  input  logic [mem_bus_pkg::BUS_W-1:0]  w_data_i,
  input  logic [mem_bus_pkg::STRB_W-1:0] w_strb_i,
  output logic                           b_valid_o
);

  logic [mem_bus_pkg::BUS_W-1:0] mem [mem_bus_pkg::MEM_WORDS];

  logic rd_pend_q;
  logic wr_pend_q;
  logic busy;
  logic ar_fire;
  logic aw_fire;

  logic [mem_bus_pkg::MEM_IDX_W-1:0] rd_idx_q;
  logic [mem_bus_pkg::MEM_IDX_W-1:0] wr_idx_q;
  logic [mem_bus_pkg::BUS_W-1:0]     wr_data_q;
  logic [mem_bus_pkg::STRB_W-1:0]    wr_strb_q;

  assign busy = rd_pend_q | wr_pend_q;

  // write wins when both channels are valid
  assign aw_ready_o = ~busy;
  assign ar_ready_o = ~busy & ~aw_valid_i;

  assign aw_fire = aw_valid_i & aw_ready_o;
  assign ar_fire = ar_valid_i & ar_ready_o;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rd_pend_q <= 1'b0;
      wr_pend_q <= 1'b0;
      r_valid_o <= 1'b0;
      b_valid_o <= 1'b0;
    end
    else
    begin
      rd_pend_q <= ar_fire;
      wr_pend_q <= aw_fire;
      r_valid_o <= rd_pend_q;
      b_valid_o <= wr_pend_q;
    end
  end

  // capture the accepted transfer, bits above the index wrap
  always_ff @(posedge clk)
  begin
    if (ar_fire)
      rd_idx_q <= ar_addr_i[mem_bus_pkg::MEM_IDX_W+2:3];
    if (aw_fire)
    begin
      wr_idx_q  <= aw_addr_i[mem_bus_pkg::MEM_IDX_W+2:3];
      wr_data_q <= w_data_i;
      wr_strb_q <= w_strb_i;
    end
  end

  // array access one cycle after accept
  always_ff @(posedge clk)
  begin
    if (wr_pend_q)
    begin
      for (int b = 0; b < mem_bus_pkg::STRB_W; b++)
      begin
        if (wr_strb_q[b])
          mem[wr_idx_q][8*b +: 8] <= wr_data_q[8*b +: 8];
      end
    end
    if (rd_pend_q)
      r_data_o <= mem[rd_idx_q];
  end

endmodule

// ==== src/mem_subsys_top.sv ====
module mem_subsys_top (
  input  logic                           clk,
  input  logic                           rst,
  // fetch
  input  logic                           ifu_req_valid_i,
  output logic                           ifu_req_ready_o,
  input  logic [mem_bus_pkg::ADDR_W-1:0] ifu_addr_i,
  output logic                           ifu_rsp_valid_o,
  output logic [mem_bus_pkg::DATA_W-1:0] ifu_rsp_data_o,
  // load/store
  input  logic                           lsu_req_valid_i,
  output logic                           lsu_req_ready_o,
  input  logic                           lsu_we_i,
  input  logic [mem_bus_pkg::ADDR_W-1:0] lsu_addr_i,
  input  logic [mem_bus_pkg::SIZE_W-1:0] lsu_size_i,
  input  logic [mem_bus_pkg::DATA_W-1:0] lsu_wdata_i,
  output logic                           lsu_rsp_valid_o,
  output logic [mem_bus_pkg::DATA_W-1:0] lsu_rsp_data_o
);

  // shared bus
  logic                           ar_valid;
  logic                           ar_ready;
  logic [mem_bus_pkg::ADDR_W-1:0] ar_addr;
  logic                           r_valid;
  logic [mem_bus_pkg::BUS_W-1:0]  r_data;
  logic                           aw_valid;
  logic                           aw_ready;
  logic [mem_bus_pkg::ADDR_W-1:0] aw_addr;
  logic [mem_bus_pkg::BUS_W-1:0]  w_data;
  logic [mem_bus_pkg::STRB_W-1:0] w_strb;
  logic                           b_valid;

  // timer path
  logic                           tmr_rd_valid;
  logic                           tmr_rd_hi;
  logic                           tmr_rsp_valid;
  logic [mem_bus_pkg::DATA_W-1:0] tmr_rsp_data;

  bus_arbiter u_bus_arbiter (
    .clk             (clk),
    .rst             (rst),
    .ifu_req_valid_i (ifu_req_valid_i),
    .ifu_req_ready_o (ifu_req_ready_o),
    .ifu_addr_i      (ifu_addr_i),
    .ifu_rsp_valid_o (ifu_rsp_valid_o),
    .ifu_rsp_data_o  (ifu_rsp_data_o),
    .lsu_req_valid_i (lsu_req_valid_i),
    .lsu_req_ready_o (lsu_req_ready_o),
    .lsu_we_i        (lsu_we_i),
    .lsu_addr_i      (lsu_addr_i),
    .lsu_size_i      (lsu_size_i),
    .lsu_wdata_i     (lsu_wdata_i),
    .lsu_rsp_valid_o (lsu_rsp_valid_o),
    .lsu_rsp_data_o  (lsu_rsp_data_o),
    .ar_valid_o      (ar_valid),
    .ar_ready_i      (ar_ready),
    .ar_addr_o       (ar_addr),
    .r_valid_i       (r_valid),
    .r_data_i        (r_data),
    .aw_valid_o      (aw_valid),
    .aw_ready_i      (aw_ready),
    .aw_addr_o       (aw_addr),
    .w_data_o        (w_data),
    .w_strb_o        (w_strb),
    .b_valid_i       (b_valid),
    .tmr_rd_valid_o  (tmr_rd_valid),
    .tmr_rd_hi_o     (tmr_rd_hi),
    .tmr_rsp_valid_i (tmr_rsp_valid),
    .tmr_rsp_data_i  (tmr_rsp_data)
  );

  clint_timer u_clint_timer (
    .clk         (clk),
    .rst         (rst),
    .rd_valid_i  (tmr_rd_valid),
    .rd_hi_i     (tmr_rd_hi),
    .rsp_valid_o (tmr_rsp_valid),
    .rsp_data_o  (tmr_rsp_data)
  );

  sram_slave u_sram_slave (
    .clk        (clk),
    .rst        (rst),
    .ar_valid_i (ar_valid),
    .ar_ready_o (ar_ready),
    .ar_addr_i  (ar_addr),
    .r_valid_o  (r_valid),
    .r_data_o   (r_data),
    .aw_valid_i (aw_valid),
    .aw_ready_o (aw_ready),
    .aw_addr_i  (aw_addr),
    .w_data_i   (w_data),
    .w_strb_i   (w_strb),
    .b_valid_o  (b_valid)
  );

endmodule

// ==== sim/tb_mem_subsys.sv ====
module tb_mem_subsys;

  // 80 round trip, 2 x 28 lane, 10 fetch, 8 arbitration, 9 timer
  localparam int PLANNED = 80 + 56 + 10 + 8 + 9;
  localparam int LIMIT   = 12 * PLANNED + 200;

  logic        clk;
  logic        rst;
  logic        ifu_req_valid_i;
  logic        ifu_req_ready_o;
  logic [31:0] ifu_addr_i;
  logic        ifu_rsp_valid_o;
  logic [31:0] ifu_rsp_data_o;
  logic        lsu_req_valid_i;
  logic        lsu_req_ready_o;
  logic        lsu_we_i;
  logic [31:0] lsu_addr_i;
  logic [1:0]  lsu_size_i;
  logic [31:0] lsu_wdata_i;
  logic        lsu_rsp_valid_o;
  logic [31:0] lsu_rsp_data_o;

  logic [7:0]  shadow [2048]; // byte image of the sram over addr[10:0]
  logic [31:0] lsu_exp_q [$];
  bit          lsu_tmr_q [$]; // entry is a timer lower bound
  logic [31:0] ifu_exp_q [$];
  logic [31:0] written_q [$];
  logic [31:0] lsu_head;
  logic [31:0] ifu_head;
  bit          lsu_head_tmr;
  int          lsu_pend;
  int          ifu_pend;
  logic [31:0] lsu_last;
  logic [31:0] cyc;           // cycles since reset release
  logic [15:0] lfsr_q = 16'd62340;
  logic        rst_d;
  int          rst_cnt;
  int          tick;
  int          err_cnt;
  int          err_mark;
  int          pass_cnt;
  int          fail_cnt;

  mem_subsys_top u_mem_subsys_top (.*);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] next_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ 16'hb400 : lfsr_q >> 1;
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic void store_shadow(logic [31:0] addr, logic [1:0] size, logic [31:0] data);
    for (int i = 0; i < (1 << size); i++)
      shadow[(addr + i) & 32'h7ff] = data[8*i +: 8];
  endfunction

  function automatic logic [31:0] load_shadow(logic [31:0] addr, logic [1:0] size);
    logic [31:0] v;
    v = '0; // zero extend
    for (int i = 0; i < (1 << size); i++)
      v[8*i +: 8] = shadow[(addr + i) & 32'h7ff];
    return v;
  endfunction

  function automatic void refresh_heads();
    lsu_pend     = lsu_exp_q.size();
    ifu_pend     = ifu_exp_q.size();
    lsu_head     = (lsu_pend > 0) ? lsu_exp_q[0] : '0;
    lsu_head_tmr = (lsu_pend > 0) ? lsu_tmr_q[0] : 1'b0;
    ifu_head     = (ifu_pend > 0) ? ifu_exp_q[0] : '0;
  endfunction

  task automatic data_mismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
    $display("error %0t: %s got %h expected %h", $time, what, got, exp);
    err_cnt++;
  endtask

  task automatic note_failure(input string what);
    $display("%s at time %0t", what, $time);
    err_cnt++;
  endtask

  task automatic lsu_txn(input logic we, input logic [31:0] addr, input logic [1:0] size,
                         input logic [31:0] wdata, output logic [31:0] hs_cyc);
    bit tmr;
    tmr = (addr == mem_bus_pkg::MTIME_LO_ADDR) || (addr == mem_bus_pkg::MTIME_HI_ADDR);
    lsu_req_valid_i = 1'b1;
    lsu_we_i        = we;
    lsu_addr_i      = addr;
    lsu_size_i      = size;
    lsu_wdata_i     = wdata;
    @(negedge clk);
    while (!lsu_req_ready_o)
      @(negedge clk);
    hs_cyc = cyc; // handshake at the coming edge
    if (tmr && !we && addr == mem_bus_pkg::MTIME_LO_ADDR)
    begin
      lsu_exp_q.push_back(cyc);
      lsu_tmr_q.push_back(1'b1);
    end
    else
    begin
      lsu_exp_q.push_back((we || tmr) ? 32'h0 : load_shadow(addr, size));
      lsu_tmr_q.push_back(1'b0);
    end
    if (we && !tmr)
      store_shadow(addr, size, wdata);
    refresh_heads();
    @(posedge clk);
    #2;
    lsu_req_valid_i = 1'b0;
  endtask

  task automatic ifu_txn(input logic [31:0] addr, output logic [31:0] hs_cyc);
    ifu_req_valid_i = 1'b1;
    ifu_addr_i      = addr;
    @(negedge clk);
    while (!ifu_req_ready_o)
      @(negedge clk);
    hs_cyc = cyc;
    ifu_exp_q.push_back(load_shadow(addr, mem_bus_pkg::SIZE_WORD));
    refresh_heads();
    @(posedge clk);
    #2;
    ifu_req_valid_i = 1'b0;
  endtask

  task automatic drain();
    while (lsu_pend != 0 || ifu_pend != 0)
      @(negedge clk);
    @(posedge clk);
    #2;
  endtask

  task automatic close_test(input string name);
    if (err_cnt == err_mark)
    begin
      pass_cnt++;
      $display("test %s passed", name);
    end
    else
    begin
      fail_cnt++;
      $display("test %s failed", name);
    end
    err_mark = err_cnt;
  endtask

  // retire expectations as responses arrive
  always @(posedge clk)
  begin
    if (!rst && lsu_rsp_valid_o && lsu_pend > 0)
    begin
      lsu_last = lsu_rsp_data_o;
      void'(lsu_exp_q.pop_front());
      void'(lsu_tmr_q.pop_front());
    end
    if (!rst && ifu_rsp_valid_o && ifu_pend > 0)
      void'(ifu_exp_q.pop_front());
    refresh_heads();
  end

  always @(posedge clk)
  begin
    rst_d <= rst;
    tick  <= tick + 1;
    if (rst)
    begin
      rst_cnt <= rst_cnt + 1;
      cyc     <= '0;
    end
    else
      cyc <= cyc + 1;
    if (tick == LIMIT)
    begin
      $display("simulation timed out after %0d cycles", tick);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  assert property (@(posedge clk) rst && rst_cnt > 0 |->
    !ifu_req_ready_o && !lsu_req_ready_o && !ifu_rsp_valid_o && !lsu_rsp_valid_o)
  else note_failure("ready or response active during reset");
  assert property (@(posedge clk) rst_d && !rst |->
    !ifu_req_ready_o && !lsu_req_ready_o && !ifu_rsp_valid_o && !lsu_rsp_valid_o)
  else note_failure("ready or response active in the first cycle after reset");
  assert property (@(posedge clk) disable iff (rst) lsu_req_valid_i |-> !ifu_req_ready_o)
  else note_failure("fetch was ready while a load/store was waiting");
  assert property (@(posedge clk) disable iff (rst) lsu_rsp_valid_o |-> lsu_pend > 0)
  else note_failure("response on the load/store port with nothing outstanding");
  assert property (@(posedge clk) disable iff (rst) ifu_rsp_valid_o |-> ifu_pend > 0)
  else note_failure("response on the fetch port with nothing outstanding");
  assert property (@(posedge clk) disable iff (rst)
    lsu_rsp_valid_o && lsu_pend > 0 && !lsu_head_tmr |-> lsu_rsp_data_o == lsu_head)
  else data_mismatch("load/store data", $sampled(lsu_rsp_data_o), $sampled(lsu_head));
  assert property (@(posedge clk) disable iff (rst)
    lsu_rsp_valid_o && lsu_pend > 0 && lsu_head_tmr |->
    lsu_rsp_data_o >= lsu_head && lsu_rsp_data_o <= cyc)
  else data_mismatch("timer low half, bound", $sampled(lsu_rsp_data_o), $sampled(lsu_head));
  assert property (@(posedge clk) disable iff (rst)
    ifu_rsp_valid_o && ifu_pend > 0 |-> ifu_rsp_data_o == ifu_head)
  else data_mismatch("fetch data", $sampled(ifu_rsp_data_o), $sampled(ifu_head));

  initial
  begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] hs_l;
    logic [31:0] hs_f;
    logic [31:0] t0;
    rst             = 1'b1;
    ifu_req_valid_i = 1'b0;
    ifu_addr_i      = '0;
    lsu_req_valid_i = 1'b0;
    lsu_we_i        = 1'b0;
    lsu_addr_i      = '0;
    lsu_size_i      = '0;
    lsu_wdata_i     = '0;
    refresh_heads();
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    close_test("reset");

    for (int i = 0; i < 40; i++)
    begin
      a = next_bits(32) & 32'h7fc;
      lsu_txn(1'b1, a, mem_bus_pkg::SIZE_WORD, next_bits(32), hs_l);
      written_q.push_back(a);
      b = written_q[next_bits(8) % written_q.size()];
      lsu_txn(1'b0, b, mem_bus_pkg::SIZE_WORD, '0, hs_l);
    end
    drain();
    close_test("word round trip");

    for (int k = 0; k < 2; k++)
    begin
      b = next_bits(8) << 3; // one 64-bit bus word
      for (int o = 0; o < 8; o += 4)
      begin
        lsu_txn(1'b1, b + o, mem_bus_pkg::SIZE_WORD, next_bits(32), hs_l);
        written_q.push_back(b + o);
      end
      // top offset first so a wide strobe hits a byte already stored
      for (int o = 7; o >= 0; o--)
        lsu_txn(1'b1, b + o, mem_bus_pkg::SIZE_BYTE, next_bits(32), hs_l);
      for (int o = 0; o < 8; o++)
        lsu_txn(1'b0, b + o, mem_bus_pkg::SIZE_BYTE, '0, hs_l);
      for (int o = 6; o >= 0; o -= 2)
        lsu_txn(1'b1, b + o, mem_bus_pkg::SIZE_HALF, next_bits(32), hs_l);
      for (int o = 0; o < 8; o += 2)
        lsu_txn(1'b0, b + o, mem_bus_pkg::SIZE_HALF, '0, hs_l);
      for (int o = 0; o < 8; o += 4)
        lsu_txn(1'b0, b + o, mem_bus_pkg::SIZE_WORD, '0, hs_l);
    end
    drain();
    close_test("byte and half lanes");

    for (int i = 0; i < 10; i++)
      ifu_txn(written_q[next_bits(8) % written_q.size()], hs_f);
    drain();
    close_test("fetch");

    for (int i = 0; i < 4; i++)
    begin
      a = written_q[next_bits(8) % written_q.size()];
      b = written_q[next_bits(8) % written_q.size()];
      fork
        lsu_txn(1'b0, a, mem_bus_pkg::SIZE_WORD, '0, hs_l);
        ifu_txn(b, hs_f);
      join
      assert (hs_l < hs_f)
      else note_failure("fetch handshake came before the load/store handshake");
      drain();
    end
    close_test("arbitration");

    // sram word 0xff aliases the timer addresses
    a = next_bits(32);
    lsu_txn(1'b1, 32'h7f8, mem_bus_pkg::SIZE_WORD, a, hs_l);
    lsu_txn(1'b1, 32'h7fc, mem_bus_pkg::SIZE_WORD, ~a, hs_l);
    lsu_txn(1'b0, mem_bus_pkg::MTIME_LO_ADDR, mem_bus_pkg::SIZE_WORD, '0, hs_l);
    drain();
    t0 = lsu_last;
    lsu_txn(1'b0, mem_bus_pkg::MTIME_LO_ADDR, mem_bus_pkg::SIZE_WORD, '0, hs_l);
    drain();
    assert (lsu_last > t0)
    else note_failure("second timer read did not exceed the first");
    lsu_txn(1'b0, mem_bus_pkg::MTIME_HI_ADDR, mem_bus_pkg::SIZE_WORD, '0, hs_l);
    lsu_txn(1'b1, mem_bus_pkg::MTIME_LO_ADDR, mem_bus_pkg::SIZE_WORD, next_bits(32), hs_l);
    lsu_txn(1'b0, mem_bus_pkg::MTIME_LO_ADDR, mem_bus_pkg::SIZE_WORD, '0, hs_l);
    lsu_txn(1'b0, 32'h7f8, mem_bus_pkg::SIZE_WORD, '0, hs_l);
    lsu_txn(1'b0, 32'h7fc, mem_bus_pkg::SIZE_WORD, '0, hs_l);
    drain();
    close_test("timer");

    $display("tests passed %0d failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== files.f ====
src/mem_bus_pkg.sv
src/bus_arbiter.sv
src/clint_timer.sv
src/sram_slave.sv
src/mem_subsys_top.sv
sim/tb_mem_subsys.sv
